// ==== qdr_phy_golden.txt ====
// Runs, then per run: lock tap of bits 0..17 (20 or above never locks),
// shift flag of bits 0..17, expected fail flag. Then rise/fall input pairs.
3
// Run 0, every bit locks.
03 07 00 0C 1F 05 09 02 10 0B 06 01 14 08 0A 04 0E 11
00 01 00 00 01 01 00 01 00 00 01 00 01 00 00 01 00 01
0
// Run 1, bits 2 and 14 never lock.
02 05 20 04 06 01 03 07 00 08 09 0A 02 04 3F 05 06 01
01 00 00 01 00 01 00 00 01 00 01 00 00 01 00 01 01 00
1
// Run 2, every bit locks, followed by the data path check.
00 01 02 03 04 05 06 07 08 09 0A 0B 0C 0D 0E 0F 1E 1D
01 01 00 00 01 00 01 00 01 01 00 00 01 00 01 00 01 00
0
// Rise and fall input pairs.
3FFFF 00000
00000 3FFFF
2AAAA 15555
15555 2AAAA
0F0F0 30F0F
12345 2DCBA
3C3C3 03C3C
00001 20000
1F00F 00FF0
26B4D 1952E

// ==== filelist.f ====
qdr_phy_pkg.sv
qdr_bit_train.sv
qdr_bit_correct.sv
qdr_bit_align.sv
qdr_phy_top.sv
qdr_phy_sva.sv
tb_qdr_phy.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      = tb_qdr_phy
FILELIST = filelist.f
OBJ_DIR  = obj_dir
SOURCES  = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_qdr_phy.sv ====
`timescale 1ns/1ps

module tb_qdr_phy;
  import qdr_phy_pkg::*;

  localparam int run_count    = 3;
  localparam int pair_count   = 10;
  localparam int rec_words    = 2 * data_width + 1;
  localparam int pair_base    = 1 + run_count * rec_words;
  localparam int golden_words = pair_base + 2 * pair_count;
  localparam int done_limit   = 1000;

  logic                  clk0;
  logic                  reset;
  logic                  bit_align_start;
  logic                  bit_align_done;
  logic                  bit_align_fail;
  logic [data_width-1:0] dly_inc_dec_n;
  logic [data_width-1:0] dly_en;
  logic [data_width-1:0] dly_rst;
  logic [data_width-1:0] qdr_d_rise;
  logic [data_width-1:0] qdr_d_fall;
  logic [bw_width-1:0]   qdr_bw_n_rise;
  logic [bw_width-1:0]   qdr_bw_n_fall;
  logic                  qdr_w_n;
  logic                  qdr_r_n;
  logic [addr_width-1:0] qdr_sa;
  logic [data_width-1:0] qdr_q_rise;
  logic [data_width-1:0] qdr_q_fall;
  logic [data_width-1:0] qdr_q_rise_cal;
  logic [data_width-1:0] qdr_q_fall_cal;

  logic [31:0]           golden_mem [golden_words];
  int                    lock_tap [data_width];
  logic [data_width-1:0] shift_bits;
  // Shift flags of the bits that are expected to lock.
  logic [data_width-1:0] shift_used;
  logic                  exp_fail;

  // Delay line model and pulse counters.
  int                    tap_pos [data_width];
  int                    en_count [data_width];
  int                    rst_count;
  logic [data_width-1:0] rst_word;
  logic                  en_before_rst;

  int                    w_low_cycles;
  logic                  r_low_started;
  logic                  train_seen;

  qdr_phy_top i_qdr_phy_top (.*);

  bind qdr_bit_align qdr_phy_sva i_sva (
    .clk0           (clk0),
    .reset          (reset),
    .state          (state),
    .bit_align_done (bit_align_done),
    .bit_align_fail (bit_align_fail),
    .qdr_w_n        (qdr_w_n),
    .dly_en         (dly_en),
    .dly_rst        (dly_rst)
  );

  always #10 clk0 = ~clk0;

  // --------------------------------------------------
  // Delay line model
  // --------------------------------------------------

  always @(posedge clk0) begin
    if (reset) begin
      for (int i = 0; i < data_width; i++) begin
        tap_pos[i]  <= 0;
        en_count[i] <= 0;
      end
      rst_count     <= 0;
      rst_word      <= '0;
      en_before_rst <= 1'b0;
    end else begin
      if (dly_rst != '0) begin
        rst_count <= rst_count + 1;
        rst_word  <= dly_rst;
      end
      if (dly_en != '0 && rst_count == 0) begin
        en_before_rst <= 1'b1;
      end
      for (int i = 0; i < data_width; i++) begin
        if (dly_rst[i]) begin
          tap_pos[i] <= 0;
        end else if (dly_en[i]) begin
          en_count[i] <= en_count[i] + 1;
          tap_pos[i]  <= dly_inc_dec_n[i] ? tap_pos[i] + 1 : tap_pos[i] - 1;
        end
      end
    end
  end

  // --------------------------------------------------
  // Failure reporting and compare tasks
  // --------------------------------------------------

  task stop_failing;
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task report_problem(input string text);
    $display("ERROR: %s", text);
    stop_failing;
  endtask

  task check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      stop_failing;
    end
  endtask

  task check_word(input string name, input logic [data_width-1:0] got,
                  input logic [data_width-1:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      stop_failing;
    end
  endtask

  task check_bw(input string name, input logic [bw_width-1:0] got,
                input logic [bw_width-1:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      stop_failing;
    end
  endtask

  task check_addr(input string name, input logic [addr_width-1:0] got,
                  input logic [addr_width-1:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      stop_failing;
    end
  endtask

  task check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      stop_failing;
    end
  endtask

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------

  // Memory model. While reads run, each bit answers for its current tap.
  task next_cycle;
    logic [31:0] noise_r;
    logic [31:0] noise_f;
    @(negedge clk0);
    noise_r = $urandom;
    noise_f = $urandom;
    for (int i = 0; i < data_width; i++) begin
      if (!qdr_r_n && lock_tap[i] < tap_count && tap_pos[i] == lock_tap[i]) begin
        qdr_q_rise[i] = ~shift_bits[i];
        qdr_q_fall[i] = shift_bits[i];
      end else if (!qdr_r_n) begin
        qdr_q_rise[i] = noise_r[i];
        qdr_q_fall[i] = noise_r[i];
      end else begin
        qdr_q_rise[i] = noise_r[i];
        qdr_q_fall[i] = noise_f[i];
      end
    end
  endtask

  task apply_reset;
    next_cycle;
    reset = 1'b1;
    next_cycle;
    next_cycle;
    reset = 1'b0;
    next_cycle;
  endtask

  task load_record(input int r);
    int base;
    base = 1 + r * rec_words;
    for (int i = 0; i < data_width; i++) begin
      lock_tap[i]   = int'(golden_mem[base + i]);
      shift_bits[i] = golden_mem[base + data_width + i][0];
      shift_used[i] = shift_bits[i] && (lock_tap[i] < tap_count);
    end
    exp_fail = golden_mem[base + 2 * data_width][0];
  endtask

  task watch_strobes;
    if (i_qdr_phy_top.i_bit_align.train_done) begin
      train_seen = 1'b1;
    end
    if (!qdr_w_n) begin
      if (r_low_started) begin
        report_problem("qdr_w_n went low after reads had started");
      end else begin
        w_low_cycles++;
      end
      // Training pattern goes to address zero with both bytes enabled.
      check_word("qdr_d_rise", qdr_d_rise, {data_width{1'b1}});
      check_word("qdr_d_fall", qdr_d_fall, '0);
      check_bw("qdr_bw_n_rise", qdr_bw_n_rise, '0);
      check_bw("qdr_bw_n_fall", qdr_bw_n_fall, '0);
      check_addr("qdr_sa at write", qdr_sa, '0);
    end
    if (!qdr_r_n) begin
      check_addr("qdr_sa at read", qdr_sa, '0);
    end
    if (!qdr_r_n && !r_low_started) begin
      r_low_started = 1'b1;
      check_count("qdr_w_n low cycles before first read", w_low_cycles, 1);
      check_flag("qdr_w_n at first read", qdr_w_n, 1'b1);
    end
    if (qdr_r_n && r_low_started && !train_seen) begin
      report_problem("qdr_r_n rose before training completed");
    end
    if (i_qdr_phy_top.i_bit_align.i_sva.error_count != 0) begin
      report_problem("an assertion in qdr_phy_sva failed");
    end
  endtask

  task run_training;
    int cyc;
    apply_reset;
    check_flag("bit_align_done", bit_align_done, 1'b0);
    check_flag("bit_align_fail", bit_align_fail, 1'b0);
    check_word("dly_en", dly_en, '0);
    check_word("dly_rst", dly_rst, '0);
    check_flag("qdr_w_n", qdr_w_n, 1'b1);
    check_flag("qdr_r_n", qdr_r_n, 1'b1);
    w_low_cycles  = 0;
    r_low_started = 1'b0;
    train_seen    = 1'b0;
    bit_align_start = 1'b1;
    cyc = 0;
    while (bit_align_done !== 1'b1) begin
      next_cycle;
      bit_align_start = 1'b0;
      watch_strobes;
      cyc++;
      if (cyc > done_limit) begin
        report_problem("bit_align_done did not rise within the cycle limit");
      end
    end
    check_flag("bit_align_fail", bit_align_fail, exp_fail);
    check_count("qdr_w_n low cycles", w_low_cycles, 1);
    check_count("dly_rst pulses", rst_count, 1);
    check_word("dly_rst pulse bits", rst_word, {data_width{1'b1}});
    check_flag("dly_en before dly_rst", en_before_rst, 1'b0);
    for (int i = 0; i < data_width; i++) begin
      check_count($sformatf("dly_en pulses on bit %0d", i), en_count[i],
                  (lock_tap[i] < tap_count) ? lock_tap[i] : tap_count);
    end
  endtask

  // Rise takes the older fall on shifted bits, fall takes this rise.
  task check_data_path;
    logic [data_width-1:0] prev_fall;
    logic [data_width-1:0] in_rise;
    logic [data_width-1:0] in_fall;
    logic [data_width-1:0] exp_rise;
    logic [data_width-1:0] exp_fall;
    prev_fall = qdr_q_fall;
    for (int p = 0; p <= pair_count; p++) begin
      @(negedge clk0);
      if (p > 0) begin
        check_word($sformatf("qdr_q_rise_cal pair %0d", p - 1), qdr_q_rise_cal, exp_rise);
        check_word($sformatf("qdr_q_fall_cal pair %0d", p - 1), qdr_q_fall_cal, exp_fall);
      end
      if (p < pair_count) begin
        in_rise    = golden_mem[pair_base + 2 * p][data_width-1:0];
        in_fall    = golden_mem[pair_base + 2 * p + 1][data_width-1:0];
        exp_rise   = (shift_used & prev_fall) | (~shift_used & in_rise);
        exp_fall   = (shift_used & in_rise) | (~shift_used & in_fall);
        qdr_q_rise = in_rise;
        qdr_q_fall = in_fall;
        prev_fall  = in_fall;
      end
    end
  endtask

  initial begin
    int unsigned seed_val;
    clk0            = 1'b0;
    reset           = 1'b1;
    bit_align_start = 1'b0;
    qdr_q_rise      = '0;
    qdr_q_fall      = '0;
    seed_val        = $urandom(64);
    $readmemh("qdr_phy_golden.txt", golden_mem);
    if (golden_mem[0] !== 32'(run_count)) begin
      report_problem("golden file does not hold the expected number of runs");
    end
    for (int r = 0; r < run_count; r++) begin
      load_record(r);
      run_training;
    end
    check_data_path;
    if (i_qdr_phy_top.i_bit_align.i_sva.error_count == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      report_problem("an assertion in qdr_phy_sva failed");
    end
  end

endmodule

// ==== qdr_phy_sva.sv ====
`timescale 1ns/1ps

module qdr_phy_sva (
  input logic                               clk0,
  input logic                               reset,
  input qdr_phy_pkg::align_state_t          state,
  input logic                               bit_align_done,
  input logic                               bit_align_fail,
  input logic                               qdr_w_n,
  input logic [qdr_phy_pkg::data_width-1:0] dly_en,
  input logic [qdr_phy_pkg::data_width-1:0] dly_rst
);
  import qdr_phy_pkg::*;

  // Failed assertions so far.
  int error_count = 0;

  // A tap step and a tap reset never share a cycle on one bit.
  step_apart_from_reset: assert property (@(posedge clk0) disable iff (reset)
    (dly_en & dly_rst) == '0)
    else begin
      error_count++;
      $error("dly_en and dly_rst high on the same bit");
    end

  // Done and its fail flag hold until reset.
  done_held: assert property (@(posedge clk0) disable iff (reset)
    bit_align_done |=> bit_align_done)
    else begin
      error_count++;
      $error("bit_align_done fell before reset");
    end

  fail_held: assert property (@(posedge clk0) disable iff (reset)
    bit_align_done |=> $stable(bit_align_fail))
    else begin
      error_count++;
      $error("bit_align_fail changed while done was high");
    end

  // --------------------------------------------------
  // Write strobe follows the write state by one cycle.
  // --------------------------------------------------

  write_strobe_source: assert property (@(posedge clk0) disable iff (reset)
    !qdr_w_n |-> $past(state) == state_write)
    else begin
      error_count++;
      $error("qdr_w_n low without a write state one cycle before");
    end

  write_strobe_follows: assert property (@(posedge clk0) disable iff (reset)
    (state == state_write) |=> !qdr_w_n)
    else begin
      error_count++;
      $error("qdr_w_n stayed high after the write state");
    end

endmodule

// ==== qdr_phy_top.sv ====
`timescale 1ns/1ps

module qdr_phy_top (
  input  logic                               clk0,
  input  logic                               reset,

  input  logic                               bit_align_start,
  output logic                               bit_align_done,
  output logic                               bit_align_fail,

  // To the input delay cells.
  output logic [qdr_phy_pkg::data_width-1:0] dly_inc_dec_n,
  output logic [qdr_phy_pkg::data_width-1:0] dly_en,
  output logic [qdr_phy_pkg::data_width-1:0] dly_rst,

  // To and from the memory.
  output logic [qdr_phy_pkg::data_width-1:0] qdr_d_rise,
  output logic [qdr_phy_pkg::data_width-1:0] qdr_d_fall,
  output logic [qdr_phy_pkg::bw_width-1:0]   qdr_bw_n_rise,
  output logic [qdr_phy_pkg::bw_width-1:0]   qdr_bw_n_fall,
  output logic                               qdr_w_n,
  output logic                               qdr_r_n,
  output logic [qdr_phy_pkg::addr_width-1:0] qdr_sa,
  input  logic [qdr_phy_pkg::data_width-1:0] qdr_q_rise,
  input  logic [qdr_phy_pkg::data_width-1:0] qdr_q_fall,

  // Read data after bit alignment.
  output logic [qdr_phy_pkg::data_width-1:0] qdr_q_rise_cal,
  output logic [qdr_phy_pkg::data_width-1:0] qdr_q_fall_cal
);

  qdr_bit_align i_bit_align (
    .clk0            (clk0),
    .reset           (reset),
    .bit_align_start (bit_align_start),
    .bit_align_done  (bit_align_done),
    .bit_align_fail  (bit_align_fail),
    .dly_inc_dec_n   (dly_inc_dec_n),
    .dly_en          (dly_en),
    .dly_rst         (dly_rst),
    .qdr_d_rise      (qdr_d_rise),
    .qdr_d_fall      (qdr_d_fall),
    .qdr_q_rise      (qdr_q_rise),
    .qdr_q_fall      (qdr_q_fall),
    .qdr_bw_n_rise   (qdr_bw_n_rise),
    .qdr_bw_n_fall   (qdr_bw_n_fall),
    .qdr_w_n         (qdr_w_n),
    .qdr_r_n         (qdr_r_n),
    .qdr_sa          (qdr_sa),
    .qdr_q_rise_cal  (qdr_q_rise_cal),
    .qdr_q_fall_cal  (qdr_q_fall_cal)
  );

endmodule

// ==== qdr_bit_align.sv ====
`timescale 1ns/1ps

module qdr_bit_align (
  input  logic                               clk0,
  input  logic                               reset,

  input  logic                               bit_align_start,
  output logic                               bit_align_done,
  output logic                               bit_align_fail,

  output logic [qdr_phy_pkg::data_width-1:0] dly_inc_dec_n,
  output logic [qdr_phy_pkg::data_width-1:0] dly_en,
  output logic [qdr_phy_pkg::data_width-1:0] dly_rst,

  output logic [qdr_phy_pkg::data_width-1:0] qdr_d_rise,
  output logic [qdr_phy_pkg::data_width-1:0] qdr_d_fall,
  input  logic [qdr_phy_pkg::data_width-1:0] qdr_q_rise,
  input  logic [qdr_phy_pkg::data_width-1:0] qdr_q_fall,
  output logic [qdr_phy_pkg::bw_width-1:0]   qdr_bw_n_rise,
  output logic [qdr_phy_pkg::bw_width-1:0]   qdr_bw_n_fall,
  output logic                               qdr_w_n,
  output logic                               qdr_r_n,
  output logic [qdr_phy_pkg::addr_width-1:0] qdr_sa,

  output logic [qdr_phy_pkg::data_width-1:0] qdr_q_rise_cal,
  output logic [qdr_phy_pkg::data_width-1:0] qdr_q_fall_cal
);
  import qdr_phy_pkg::*;

  align_state_t state;

  logic                    train_start;
  logic                    train_done;
  logic                    train_fail;
  logic [data_width-1:0]   aligned;
  logic [wait_width-1:0]   wait_cnt;
  logic [finish_width-1:0] finish_cnt;

  // --------------------------------------------------
  // Calibration sequencer
  // --------------------------------------------------

  always_ff @(posedge clk0) begin
    if (reset) begin
      state          <= state_idle;
      train_start    <= 1'b0;
      bit_align_fail <= 1'b0;
      wait_cnt       <= '0;
      finish_cnt     <= '0;
    end else begin
      train_start <= 1'b0;
      case (state)
        state_idle: begin
          if (bit_align_start) begin
            state <= state_write;
          end
        end
        state_write: begin
          wait_cnt <= wait_width'(read_wait_cycles - 1);
          state    <= state_wait;
        end
        state_wait: begin
          // Let the pattern land in memory before training starts.
          if (wait_cnt == '0) begin
            train_start <= 1'b1;
            state       <= state_train;
          end else begin
            wait_cnt <= wait_cnt - 1'b1;
          end
        end
        state_train: begin
          if (train_done) begin
            bit_align_fail <= train_fail;
            state          <= state_align;
          end
        end
        state_align: begin
          finish_cnt <= finish_width'(finish_cycles - 1);
          state      <= state_finish;
        end
        state_finish: begin
          if (finish_cnt == '0) begin
            state <= state_done;
          end else begin
            finish_cnt <= finish_cnt - 1'b1;
          end
        end
        state_done: begin
          // Held until reset.
          state <= state_done;
        end
        default: state <= state_idle;
      endcase
    end
  end

  assign bit_align_done = (state == state_done);

  // --------------------------------------------------
  // Memory command strobes and training pattern
  // --------------------------------------------------

  // One cycle behind the state, active low.
  always_ff @(posedge clk0) begin
    if (reset) begin
      qdr_w_n <= 1'b1;
      qdr_r_n <= 1'b1;
    end else begin
      qdr_w_n <= (state != state_write);
      qdr_r_n <= !(state == state_wait || state == state_train || state == state_align);
    end
  end

  assign qdr_d_rise    = {data_width{1'b1}};
  assign qdr_d_fall    = {data_width{1'b0}};
  assign qdr_bw_n_rise = {bw_width{1'b0}};
  assign qdr_bw_n_fall = {bw_width{1'b0}};
  assign qdr_sa        = {addr_width{1'b0}};

  // --------------------------------------------------
  // Tap search and per-bit correction
  // --------------------------------------------------

  qdr_bit_train i_bit_train (
    .clk0          (clk0),
    .reset         (reset),
    .train_start   (train_start),
    .q_rise        (qdr_q_rise),
    .q_fall        (qdr_q_fall),
    .train_done    (train_done),
    .train_fail    (train_fail),
    .aligned       (aligned),
    .dly_inc_dec_n (dly_inc_dec_n),
    .dly_en        (dly_en),
    .dly_rst       (dly_rst)
  );

  qdr_bit_correct i_bit_correct [data_width-1:0] (
    .clk0           (clk0),
    .reset          (reset),
    .aligned        (aligned),
    .qdr_q_rise     (qdr_q_rise),
    .qdr_q_fall     (qdr_q_fall),
    .qdr_q_rise_cal (qdr_q_rise_cal),
    .qdr_q_fall_cal (qdr_q_fall_cal)
  );

endmodule

// ==== qdr_bit_correct.sv ====
`timescale 1ns/1ps

module qdr_bit_correct (
  input  logic clk0,
  input  logic reset,
  input  logic aligned,
  input  logic qdr_q_rise,
  input  logic qdr_q_fall,
  output logic qdr_q_rise_cal,
  output logic qdr_q_fall_cal
);

  // Fall sample of the previous cycle.
  logic fall_prev;

  always_ff @(posedge clk0) begin
    if (reset) begin
      fall_prev      <= 1'b0;
      qdr_q_rise_cal <= 1'b0;
      qdr_q_fall_cal <= 1'b0;
    end else begin
      fall_prev <= qdr_q_fall;
      if (aligned) begin
        // Data arrived half a cycle late, so pair the old fall with this rise.
        qdr_q_rise_cal <= fall_prev;
        qdr_q_fall_cal <= qdr_q_rise;
      end else begin
        qdr_q_rise_cal <= qdr_q_rise;
        qdr_q_fall_cal <= qdr_q_fall;
      end
    end
  end

endmodule

// ==== qdr_bit_train.sv ====
`timescale 1ns/1ps

module qdr_bit_train (
  input  logic                               clk0,
  input  logic                               reset,
  input  logic                               train_start,
  input  logic [qdr_phy_pkg::data_width-1:0] q_rise,
  input  logic [qdr_phy_pkg::data_width-1:0] q_fall,
  output logic                               train_done,
  output logic                               train_fail,
  output logic [qdr_phy_pkg::data_width-1:0] aligned,
  output logic [qdr_phy_pkg::data_width-1:0] dly_inc_dec_n,
  output logic [qdr_phy_pkg::data_width-1:0] dly_en,
  output logic [qdr_phy_pkg::data_width-1:0] dly_rst
);
  import qdr_phy_pkg::*;

  logic                    active;
  logic [settle_width-1:0] settle_cnt;
  logic                    sample;

  logic [tap_width-1:0]  tap_cnt [data_width];
  logic [data_width-1:0] locked;
  logic [data_width-1:0] exhausted;

  // Registered copy of the returned read data.
  logic [data_width-1:0] q_rise_s;
  logic [data_width-1:0] q_fall_s;

  logic [data_width-1:0] bit_busy;
  logic [data_width-1:0] hit_direct;
  logic [data_width-1:0] hit_shifted;
  logic [data_width-1:0] lock_now;
  logic [data_width-1:0] step;
  logic [data_width-1:0] last_tap;
  logic [data_width-1:0] exhaust_now;
  logic [data_width-1:0] finished;

  // The search only ever moves a bit later.
  assign dly_inc_dec_n = {data_width{1'b1}};

  always_ff @(posedge clk0) begin
    q_rise_s <= q_rise;
    q_fall_s <= q_fall;
  end

  // --------------------------------------------------
  // Per-bit pattern decode
  // --------------------------------------------------

  // Rise ones and fall zeros is the direct pattern.
  assign hit_direct  = q_rise_s & ~q_fall_s;
  assign hit_shifted = ~q_rise_s & q_fall_s;

  assign bit_busy    = ~(locked | exhausted);
  assign lock_now    = bit_busy & (hit_direct | hit_shifted);
  assign step        = bit_busy & ~(hit_direct | hit_shifted);
  assign exhaust_now = step & last_tap;
  assign finished    = ~bit_busy | lock_now | exhaust_now;

  always_comb begin
    for (int i = 0; i < data_width; i++) begin
      last_tap[i] = (tap_cnt[i] == tap_width'(tap_count - 1));
    end
  end

  assign sample = active && (settle_cnt == '0);

  // --------------------------------------------------
  // Tap search
  // --------------------------------------------------

  always_ff @(posedge clk0) begin
    if (reset) begin
      active     <= 1'b0;
      settle_cnt <= '0;
      locked     <= '0;
      exhausted  <= '0;
      aligned    <= '0;
      dly_en     <= '0;
      dly_rst    <= '0;
      train_done <= 1'b0;
      train_fail <= 1'b0;
      for (int i = 0; i < data_width; i++) begin
        tap_cnt[i] <= '0;
      end
    end else begin
      dly_en     <= '0;
      dly_rst    <= '0;
      train_done <= 1'b0;
      if (train_start) begin
        // Back to tap zero on every bit.
        active     <= 1'b1;
        settle_cnt <= settle_width'(settle_cycles - 1);
        locked     <= '0;
        exhausted  <= '0;
        aligned    <= '0;
        dly_rst    <= '1;
        train_fail <= 1'b0;
        for (int i = 0; i < data_width; i++) begin
          tap_cnt[i] <= '0;
        end
      end else if (sample) begin
        settle_cnt <= settle_width'(settle_cycles - 1);
        locked     <= locked | lock_now;
        aligned    <= aligned | (lock_now & hit_shifted);
        exhausted  <= exhausted | exhaust_now;
        dly_en     <= step;
        for (int i = 0; i < data_width; i++) begin
          if (step[i] && !last_tap[i]) begin
            tap_cnt[i] <= tap_cnt[i] + 1'b1;
          end
        end
        if (&finished) begin
          active     <= 1'b0;
          train_done <= 1'b1;
          train_fail <= |(exhausted | exhaust_now);
        end
      end else if (active) begin
        settle_cnt <= settle_cnt - 1'b1;
      end
    end
  end

endmodule

// ==== qdr_phy_pkg.sv ====
package qdr_phy_pkg;

  // --------------------------------------------------
  // Bus widths
  // --------------------------------------------------

  // Read and write data bits, one QDR word.
  localparam int data_width = 18;

  // Byte-write enables per word.
  localparam int bw_width = 2;

  localparam int addr_width = 21;

  // --------------------------------------------------
  // Training limits
  // --------------------------------------------------

  // Input delay taps per bit; a bit not locked after all of them has failed.
  localparam int tap_count = 32;
  localparam int tap_width = 5;

  // Cycles between a tap step and the next sample.
  localparam int settle_cycles = 4;
  localparam int settle_width  = $clog2(settle_cycles);

  // Cycles from the write strobe to the start of training.
  localparam int read_wait_cycles = 16;
  localparam int wait_width       = $clog2(read_wait_cycles);

  // Cycles spent in finish before done is raised.
  localparam int finish_cycles = 8;
  localparam int finish_width  = $clog2(finish_cycles);

  // --------------------------------------------------
  // Sequencer states
  // --------------------------------------------------

  typedef enum logic [2:0] {
    state_idle   = 3'd0,
    state_write  = 3'd1,
    state_wait   = 3'd2,
    state_train  = 3'd3,
    state_align  = 3'd4,
    state_finish = 3'd5,
    state_done   = 3'd6
  } align_state_t;

endpackage
